// File: src/crc_cfg.svh
/* build-time settings for the CRC-32 engine (MPEG-2 variant, MSB first)
   CRC_BITS_PER_CYCLE must divide 32 */
`ifndef CRC_CFG_SVH
`define CRC_CFG_SVH

// parallel lanes, one whole message per lane
`define CRC_NUM_LANES 4

// non-reflected CRC-32, no final xor
`define CRC_POLY 32'h04C11DB7

// seed at the start of each message
`define CRC_INIT 32'hFFFFFFFF

// message bits folded in per clock
`define CRC_BITS_PER_CYCLE 8

`endif

// File: src/crc_pkg.sv
/* shared types of the CRC engine, widths follow crc_cfg.svh */
`include "crc_cfg.svh"

package crc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] crc_t;

    // at least one bit even for a single lane
    typedef logic [((`CRC_NUM_LANES > 1) ? $clog2(`CRC_NUM_LANES) : 1)-1:0] lane_id_t;

    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_WAIT_ACK,
        DISP_WAIT_DROP
    } disp_state_e;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_SHIFT,
        LANE_WAIT_DROP,
        LANE_RESULT
    } lane_state_e;

    typedef enum logic [1:0] {
        COLL_WAIT,
        COLL_PRESENT,
        COLL_DROP
    } coll_state_e;

endpackage

// File: src/crc_dispatcher.sv
/* steers whole messages to lanes in round-robin order
   in_ack mirrors the ack of the target lane, so a busy lane stalls the input */
`timescale 1ns/1ps
`include "crc_cfg.svh"

module crc_dispatcher (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_req,
    input  crc_pkg::word_t            in_data,
    input  logic                      in_last,
    output logic                      in_ack,
    output logic [`CRC_NUM_LANES-1:0] lane_req,
    output crc_pkg::word_t            lane_data,
    output logic                      lane_last,
    input  logic [`CRC_NUM_LANES-1:0] lane_ack
);

    crc_pkg::disp_state_e state;
    crc_pkg::lane_id_t    ptr;
    crc_pkg::lane_id_t    ptr_next;
    logic                 take;

    assign take = (state == crc_pkg::DISP_IDLE) && in_req;

    // word counts as accepted only once the lane has latched it
    assign in_ack = lane_ack[ptr];

    assign ptr_next = (ptr == crc_pkg::lane_id_t'(`CRC_NUM_LANES - 1)) ? '0 : ptr + 1'b1;

    // word and last flag held for the whole lane handshake
    always_ff @(posedge clk) begin
        if (take) begin
            lane_data <= in_data;
            lane_last <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= crc_pkg::DISP_IDLE;
            ptr      <= '0;
            lane_req <= '0;
        end else begin
            case (state)
                crc_pkg::DISP_IDLE: begin
                    if (take) begin
                        lane_req[ptr] <= 1'b1;
                        state         <= crc_pkg::DISP_WAIT_ACK;
                    end
                end
                crc_pkg::DISP_WAIT_ACK: begin
                    // release the lane once the source has seen the ack
                    if (lane_ack[ptr] && !in_req) begin
                        lane_req <= '0;
                        state    <= crc_pkg::DISP_WAIT_DROP;
                    end
                end
                crc_pkg::DISP_WAIT_DROP: begin
                    if (!lane_ack[ptr]) begin
                        // message boundary, next message goes to the next lane
                        if (lane_last) begin
                            ptr <= ptr_next;
                        end
                        state <= crc_pkg::DISP_IDLE;
                    end
                end
                default: begin
                    state <= crc_pkg::DISP_IDLE;
                end
            endcase
        end
    end

    a_lane_req_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(lane_req)
    ) else $error("more than one lane request active");

endmodule

// File: src/crc_lane.sv
/* one CRC lane, folds CRC_BITS_PER_CYCLE bits per clock, MSB first
   a word is only taken after the previous one is shifted and its request dropped */
`timescale 1ns/1ps
`include "crc_cfg.svh"

module crc_lane (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           word_req,
    input  crc_pkg::word_t word_data,
    input  logic           word_last,
    output logic           word_ack,
    output logic           res_req,
    output crc_pkg::crc_t  res_crc,
    input  logic           res_ack
);

    localparam int SHIFT_CYCLES = 32 / `CRC_BITS_PER_CYCLE;
    localparam int CNT_W        = (SHIFT_CYCLES > 1) ? $clog2(SHIFT_CYCLES) : 1;

    crc_pkg::lane_state_e state;
    logic [CNT_W-1:0]     cnt;
    logic                 first_q;
    logic                 last_q;
    crc_pkg::crc_t        crc_q;
    crc_pkg::crc_t        crc_nxt;
    crc_pkg::word_t       word_q;
    crc_pkg::word_t       word_nxt;
    logic                 fb;
    logic                 load;
    logic                 shift_en;
    logic                 shift_done;

    assign load       = (state == crc_pkg::LANE_IDLE) && word_req;
    assign shift_en   = (state == crc_pkg::LANE_SHIFT);
    assign shift_done = shift_en && (cnt == CNT_W'(SHIFT_CYCLES - 1));
    assign res_crc    = crc_q;

    // unrolled shift and conditional xor
    always_comb begin
        crc_nxt  = crc_q;
        word_nxt = word_q;
        fb       = 1'b0;
        for (int i = 0; i < `CRC_BITS_PER_CYCLE; i++) begin
            fb       = crc_nxt[31] ^ word_nxt[31];
            crc_nxt  = {crc_nxt[30:0], 1'b0} ^ (fb ? `CRC_POLY : 32'h0);
            word_nxt = {word_nxt[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= word_data;
            // seed only on the first word of a message
            if (first_q) begin
                crc_q <= `CRC_INIT;
            end
        end else if (shift_en) begin
            crc_q  <= crc_nxt;
            word_q <= word_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= crc_pkg::LANE_IDLE;
            cnt      <= '0;
            first_q  <= 1'b1;
            last_q   <= 1'b0;
            word_ack <= 1'b0;
            res_req  <= 1'b0;
        end else begin
            // input ack follows the request down in any state
            if (word_ack && !word_req) begin
                word_ack <= 1'b0;
            end
            case (state)
                crc_pkg::LANE_IDLE: begin
                    if (word_req) begin
                        word_ack <= 1'b1;
                        last_q   <= word_last;
                        first_q  <= 1'b0;
                        cnt      <= '0;
                        state    <= crc_pkg::LANE_SHIFT;
                    end
                end
                crc_pkg::LANE_SHIFT: begin
                    cnt <= cnt + 1'b1;
                    if (shift_done) begin
                        if (last_q) begin
                            res_req <= 1'b1;
                            first_q <= 1'b1;
                            state   <= crc_pkg::LANE_RESULT;
                        end else begin
                            state <= crc_pkg::LANE_WAIT_DROP;
                        end
                    end
                end
                crc_pkg::LANE_WAIT_DROP: begin
                    // a low ack means the handshake already closed during the shift
                    if (!word_ack || !word_req) begin
                        state <= crc_pkg::LANE_IDLE;
                    end
                end
                crc_pkg::LANE_RESULT: begin
                    if (res_req && res_ack) begin
                        res_req <= 1'b0;
                    end
                    if (!res_req && !res_ack && !word_ack) begin
                        state <= crc_pkg::LANE_IDLE;
                    end
                end
                default: begin
                    state <= crc_pkg::LANE_IDLE;
                end
            endcase
        end
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(word_ack) |-> word_req
    ) else $error("word ack raised without a request");

    a_res_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_req && $past(res_req) |-> $stable(res_crc)
    ) else $error("result changed while offered");

endmodule

// File: src/crc_collector.sv
/* drains lane results in the same round-robin order as the dispatcher
   a lane is acked only after the output handshake has fully closed */
`timescale 1ns/1ps
`include "crc_cfg.svh"

module crc_collector (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CRC_NUM_LANES-1:0] res_req,
    input  crc_pkg::crc_t             res_crc [`CRC_NUM_LANES],
    output logic [`CRC_NUM_LANES-1:0] res_ack,
    output logic                      out_req,
    output crc_pkg::crc_t             out_crc,
    input  logic                      out_ack
);

    crc_pkg::coll_state_e state;
    crc_pkg::lane_id_t    ptr;
    crc_pkg::lane_id_t    ptr_next;
    logic                 take;

    // skip a lane whose previous result is still being released
    assign take = (state == crc_pkg::COLL_WAIT) && res_req[ptr] && !res_ack[ptr];

    assign ptr_next = (ptr == crc_pkg::lane_id_t'(`CRC_NUM_LANES - 1)) ? '0 : ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (take) begin
            out_crc <= res_crc[ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= crc_pkg::COLL_WAIT;
            ptr     <= '0;
            res_ack <= '0;
            out_req <= 1'b0;
        end else begin
            // lane acks drop once the lane has withdrawn its request
            for (int i = 0; i < `CRC_NUM_LANES; i++) begin
                if (res_ack[i] && !res_req[i]) begin
                    res_ack[i] <= 1'b0;
                end
            end
            case (state)
                crc_pkg::COLL_WAIT: begin
                    if (take) begin
                        out_req <= 1'b1;
                        state   <= crc_pkg::COLL_PRESENT;
                    end
                end
                crc_pkg::COLL_PRESENT: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= crc_pkg::COLL_DROP;
                    end
                end
                crc_pkg::COLL_DROP: begin
                    if (!out_ack) begin
                        res_ack[ptr] <= 1'b1;
                        ptr          <= ptr_next;
                        state        <= crc_pkg::COLL_WAIT;
                    end
                end
                default: begin
                    state <= crc_pkg::COLL_WAIT;
                end
            endcase
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> $stable(out_crc)
    ) else $error("out_crc changed before out_ack");

endmodule

// File: src/crc_top.sv
/* multi-lane CRC-32 engine, results leave in message arrival order
   full 32-bit words only, four-phase req/ack on both ports */
`timescale 1ns/1ps
`include "crc_cfg.svh"

module crc_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_req,
    input  crc_pkg::word_t in_data,
    input  logic           in_last,
    output logic           in_ack,
    output logic           out_req,
    output crc_pkg::crc_t  out_crc,
    input  logic           out_ack
);

    logic [`CRC_NUM_LANES-1:0] lane_req;
    logic [`CRC_NUM_LANES-1:0] lane_ack;
    crc_pkg::word_t            lane_data;
    logic                      lane_last;

    logic [`CRC_NUM_LANES-1:0] res_req;
    logic [`CRC_NUM_LANES-1:0] res_ack;
    crc_pkg::crc_t             res_crc [`CRC_NUM_LANES];

    crc_dispatcher u_disp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_ack    (in_ack),
        .lane_req  (lane_req),
        .lane_data (lane_data),
        .lane_last (lane_last),
        .lane_ack  (lane_ack)
    );

    // lanes share the word bus, each has its own req/ack pair
    for (genvar g = 0; g < `CRC_NUM_LANES; g++) begin : g_lane
        crc_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .word_req  (lane_req[g]),
            .word_data (lane_data),
            .word_last (lane_last),
            .word_ack  (lane_ack[g]),
            .res_req   (res_req[g]),
            .res_crc   (res_crc[g]),
            .res_ack   (res_ack[g])
        );
    end

    crc_collector u_coll (
        .clk     (clk),
        .rst_n   (rst_n),
        .res_req (res_req),
        .res_crc (res_crc),
        .res_ack (res_ack),
        .out_req (out_req),
        .out_crc (out_crc),
        .out_ack (out_ack)
    );

endmodule

// File: sim/tb_crc_top.sv
/* directed testbench for crc_top, inputs driven and outputs sampled 2 ns after the edge
   expected checksums come from a bitwise CRC-32 (MPEG-2) model */
`timescale 1ns/1ps
`include "crc_cfg.svh"

module tb_crc_top;

    logic           clk;
    logic           rst_n;
    logic           in_req;
    crc_pkg::word_t in_data;
    logic           in_last;
    logic           in_ack;
    logic           out_req;
    crc_pkg::crc_t  out_crc;
    logic           out_ack;

    crc_pkg::crc_t exp_q[$];
    crc_pkg::crc_t got_q[$];
    int            errors = 0;
    int            checks = 0;
    int            tests_run = 0;
    int            words_sent = 0;
    int            cycles = 0;
    int            errors_at_start;
    int            max_delay = 0;
    logic          hold_out = 1'b0;
    logic [31:0]   rng;
    string         test_name;

    crc_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .in_last (in_last),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_crc (out_crc),
        .out_ack (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // limit grows with the number of words sent so far
    initial begin
        while (cycles <= 200 * words_sent + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run stalled after %0d cycles", cycles);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one word folded in bit by bit, MSB first
    function automatic crc_pkg::crc_t crc_model(input crc_pkg::crc_t crc_in,
                                                input crc_pkg::word_t w);
        crc_pkg::crc_t  c;
        crc_pkg::word_t d;
        logic           fb;
        c = crc_in;
        d = w;
        for (int b = 0; b < 32; b++) begin
            fb = c[31] ^ d[31];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ `CRC_POLY;
            end
            d = {d[30:0], 1'b0};
        end
        return c;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: pass", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic send_word(input crc_pkg::word_t data, input logic last);
        words_sent++;
        in_data = data;
        in_last = last;
        in_req  = 1'b1;
        do tick(); while (!in_ack);
        in_req = 1'b0;
        do tick(); while (in_ack);
    endtask

    task automatic send_message(input int len, input logic rand_data,
                                input crc_pkg::word_t base);
        crc_pkg::crc_t  crc;
        crc_pkg::word_t w;
        crc = `CRC_INIT;
        for (int i = 0; i < len; i++) begin
            if (rand_data) begin
                rng = xorshift(rng);
                w = rng;
            end else begin
                w = base + crc_pkg::word_t'(i);
            end
            crc = crc_model(crc, w);
            send_word(w, (i == len - 1));
        end
        exp_q.push_back(crc);
    endtask

    task automatic drain_results();
        while (got_q.size() < exp_q.size()) begin
            tick();
        end
        while (exp_q.size() > 0) begin
            check(test_name, exp_q.pop_front(), got_q.pop_front());
        end
    endtask

    // output side, acks each result after an optional delay
    initial begin
        logic [31:0] rx_rng;
        int          wait_n;
        rx_rng  = 32'h480c_6532;
        out_ack = 1'b0;
        forever begin
            tick();
            if (rst_n && out_req && !hold_out) begin
                rx_rng = xorshift(rx_rng);
                wait_n = int'(rx_rng % 32'(max_delay + 1));
                repeat (wait_n) tick();
                out_ack = 1'b1;
                got_q.push_back(out_crc);
                while (out_req) begin
                    tick();
                end
                out_ack = 1'b0;
            end
        end
    end

    task automatic test_single_word();
        start_test("single_word");
        send_message(1, 1'b0, 32'h0000_0000);
        send_message(1, 1'b0, 32'hFFFF_FFFF);
        drain_results();
        finish_test();
    endtask

    task automatic test_back_to_back();
        start_test("back_to_back");
        for (int m = 0; m < 8; m++) begin
            send_message(m + 1, 1'b0, 32'hA500_0000 + 32'(m << 12));
        end
        drain_results();
        finish_test();
    endtask

    task automatic test_back_pressure();
        int   quiet;
        logic sent_all;
        start_test("back_pressure");
        hold_out = 1'b1;
        sent_all = 1'b0;
        quiet    = 0;
        fork
            begin
                for (int m = 0; m < 6; m++) begin
                    send_message(m + 1, 1'b0, 32'hB000_0000 + 32'(m << 8));
                end
                sent_all = 1'b1;
            end
            begin
                // input must stall once every lane holds a result
                while (quiet < 40 && !sent_all) begin
                    tick();
                    quiet = (in_req && !in_ack) ? quiet + 1 : 0;
                end
                if (sent_all) begin
                    errors++;
                    $display("%s: input never stalled while the output was held", test_name);
                end
                // first result still offered and unchanged
                check(test_name, 32'd1, 32'(out_req));
                check(test_name, exp_q[0], out_crc);
                hold_out = 1'b0;
            end
        join
        drain_results();
        finish_test();
    endtask

    task automatic test_random_stream();
        int len;
        start_test("random_stream");
        max_delay = 3;
        for (int m = 0; m < 20; m++) begin
            rng = xorshift(rng);
            len = 1 + int'(rng % 32'd6);
            send_message(len, 1'b1, 32'h0);
        end
        drain_results();
        max_delay = 0;
        finish_test();
    endtask

    task automatic test_reset_recovery();
        start_test("reset_recovery");
        // a held result and an acked word in flight when reset hits
        hold_out = 1'b1;
        send_message(1, 1'b0, 32'hC0DE_0000);
        while (!out_req) begin
            tick();
        end
        send_word(32'hC0DE_0001, 1'b0);
        in_data = 32'hC0DE_0002;
        in_last = 1'b0;
        in_req  = 1'b1;
        do tick(); while (!in_ack);
        rst_n  = 1'b0;
        in_req = 1'b0;
        repeat (2) tick();
        rst_n = 1'b1;
        tick();
        check(test_name, 32'd0, 32'(out_req));
        check(test_name, 32'd0, 32'(in_ack));
        // the held result is gone after reset
        exp_q.delete();
        hold_out = 1'b0;
        send_message(3, 1'b0, 32'h1234_5678);
        drain_results();
        finish_test();
    endtask

    initial begin
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        rng     = 32'h480c_6532;
        repeat (2) tick();
        rst_n = 1'b1;
        tick();
        test_single_word();
        test_back_to_back();
        test_back_pressure();
        test_random_stream();
        test_reset_recovery();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/crc_pkg.sv
src/crc_dispatcher.sv
src/crc_lane.sv
src/crc_collector.sv
src/crc_top.sv
sim/tb_crc_top.sv

// File: Makefile
# Verilator build and run of the CRC engine testbench
VERILATOR ?= verilator
TOP       ?= tb_crc_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

FILE_LIST := list.f
SOURCES   := $(filter-out +%,$(shell cat $(FILE_LIST))) $(wildcard src/*.svh)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
